// File: logic/nocPkg.sv
`default_nettype none

package nocPkg;

  localparam int numPorts = 5;
  localparam int bufDepth = 4;
  localparam int bufPtrW  = $clog2(bufDepth);
  localparam int bufCntW  = $clog2(bufDepth + 1);
  localparam int pktLenW  = 12;

  typedef logic [2:0]         flitKindT;
  typedef logic [15:0]        flitDataT;
  typedef logic [pktLenW-1:0] pktLenT;    // flits incl. head
  typedef logic [2:0]         portIdT;
  typedef logic [bufPtrW-1:0] bufPtrT;
  typedef logic [bufCntW-1:0] bufCntT;

  localparam flitKindT flitHead = 3'b001;
  localparam flitKindT flitBody = 3'b010;
  localparam flitKindT flitTail = 3'b100;

  localparam portIdT portLocal = 3'd0;
  localparam portIdT portNorth = 3'd1;
  localparam portIdT portEast  = 3'd2;
  localparam portIdT portWest  = 3'd3;
  localparam portIdT portSouth = 3'd4;

  typedef struct packed {
    flitKindT kind;
    flitDataT data;   // head carries the length in the low bits
  } flitT;

  typedef struct packed {
    flitT   flit;
    portIdT srcPort;
  } outFlitT;

endpackage

`default_nettype wire

// File: logic/arbPkg.sv
`default_nettype none

package arbPkg;

  localparam int pktCntW = 12;

  typedef logic [pktCntW-1:0] pktCntT;

  // one bit per channel indexed by port id
  typedef logic [nocPkg::numPorts-1:0] grantT;

  // one-hot with the grant bits above the idle bit
  typedef enum logic [5:0] {
    idle   = 6'b000001,
    grantL = 6'b000010,
    grantN = 6'b000100,
    grantE = 6'b001000,
    grantW = 6'b010000,
    grantS = 6'b100000
  } arbStateT;

endpackage

`default_nettype wire

// File: logic/flitBuffer.sv
`default_nettype none

module flitBuffer
  import nocPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  flitT inFlit,
  output logic inReady,
  input  logic pop,
  output logic notEmpty,
  output flitT headFlit
);

  flitT   mem [bufDepth];
  bufPtrT wrPtr;
  bufPtrT rdPtr;
  bufCntT count;
  logic   push;
  logic   doPop;

  assign inReady  = (count != bufCntT'(bufDepth));
  assign notEmpty = (count != '0);
  assign push     = inValid & inReady;
  assign doPop    = pop & notEmpty;   // pop on empty is dropped
  assign headFlit = mem[rdPtr];

  //**************************************************************************
  // storage
  //**************************************************************************

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  //**************************************************************************
  // pointers and occupancy
  //**************************************************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;   // power-of-two depth wraps by itself
      if (doPop)
        rdPtr <= rdPtr + 1'b1;

      case ({push, doPop})
        2'b10:
          count <= count + 1'b1;
        2'b01:
          count <= count - 1'b1;
        default:
          count <= count;   // idle or push and pop together
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/packetTimer.sv
`default_nettype none

module packetTimer
  import nocPkg::*, arbPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic xfer,
  input  flitT xferFlit,
  output logic last
);

  pktCntT count;     // flits of this packet already sent
  pktLenT limit;
  pktLenT headLen;
  logic   isHead;

  assign isHead  = (xferFlit.kind == flitHead);
  assign headLen = (xferFlit.data[pktLenW-1:0] == '0) ? pktLenT'(1)
                                                      : xferFlit.data[pktLenW-1:0];

  // a head starts over, so it is judged on its own length
  always_comb
  begin
    if (!xfer)
      last = 1'b0;
    else if (isHead)
      last = (headLen == pktLenT'(1));
    else
      last = (({1'b0, count} + 1'b1) >= {1'b0, limit});
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      limit <= pktLenT'(1);
    end
    else if (xfer)
    begin
      if (isHead)
        limit <= headLen;
      if (last)
        count <= '0;   // ready for the next head
      else if (isHead)
        count <= pktCntT'(1);
      else
        count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/portArbiter.sv
`default_nettype none

module portArbiter
  import nocPkg::*, arbPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] req,
  input  logic                xfer,
  input  flitT                xferFlit,
  output grantT               grant
);

  arbStateT state;
  arbStateT nextState;
  grantT    lastVec;
  portIdT   curPort;

  // first requester among span channels, starting at channel start
  function automatic arbStateT pickNext(input logic [numPorts-1:0] reqVec,
                                        input int start,
                                        input int span);
    arbStateT pick;
    int       idx;
    pick = idle;
    for (int k = numPorts - 1; k >= 0; k--)   // walk backwards, nearest wins
    begin
      idx = (start + k) % numPorts;
      if (k < span && reqVec[idx])
        pick = arbStateT'(6'b000010 << idx);
    end
    return pick;
  endfunction

  assign grant = state[numPorts:1];

  always_comb
  begin
    curPort = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p])
        curPort = portIdT'(p);
    end
  end

  //**************************************************************************
  // packet timers counting only while their channel is granted
  //**************************************************************************

  packetTimer timerL (
    .clk      (clk),
    .rst      (rst),
    .xfer     (xfer & grant[portLocal]),
    .xferFlit (xferFlit),
    .last     (lastVec[portLocal])
  );

  packetTimer timerN (
    .clk      (clk),
    .rst      (rst),
    .xfer     (xfer & grant[portNorth]),
    .xferFlit (xferFlit),
    .last     (lastVec[portNorth])
  );

  packetTimer timerE (
    .clk      (clk),
    .rst      (rst),
    .xfer     (xfer & grant[portEast]),
    .xferFlit (xferFlit),
    .last     (lastVec[portEast])
  );

  packetTimer timerW (
    .clk      (clk),
    .rst      (rst),
    .xfer     (xfer & grant[portWest]),
    .xferFlit (xferFlit),
    .last     (lastVec[portWest])
  );

  packetTimer timerS (
    .clk      (clk),
    .rst      (rst),
    .xfer     (xfer & grant[portSouth]),
    .xferFlit (xferFlit),
    .last     (lastVec[portSouth])
  );

  //**************************************************************************
  // grant FSM
  //**************************************************************************

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= idle;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      idle:
        nextState = pickNext(req, 0, numPorts);   // fixed L first
      grantL, grantN, grantE, grantW, grantS:
      begin
        // finishing channel left out since its request may be stale
        if (|lastVec)
          nextState = pickNext(req, int'(curPort) + 1, numPorts - 1);
      end
      default:
        nextState = idle;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/outputMux.sv
`default_nettype none

module outputMux
  import nocPkg::*, arbPkg::*;
(
  input  grantT               grant,
  input  logic [numPorts-1:0] notEmpty,
  input  flitT                headFlit [numPorts],
  input  logic                outReady,
  output logic                outValid,
  output outFlitT             outFlit,
  output logic                xfer,
  output flitT                xferFlit,
  output logic [numPorts-1:0] pop
);

  flitT   selFlit;
  portIdT srcPort;
  logic   selValid;

  // grant is one-hot, so OR-ing the gated heads is the mux
  always_comb
  begin
    selFlit  = '0;
    srcPort  = '0;
    selValid = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p])
      begin
        selFlit  = selFlit | headFlit[p];
        srcPort  = srcPort | portIdT'(p);
        selValid = selValid | notEmpty[p];
      end
    end
  end

  assign outValid = selValid;
  assign outFlit  = '{flit: selFlit, srcPort: srcPort};
  assign xfer     = outValid & outReady;
  assign xferFlit = selFlit;
  assign pop      = grant & {numPorts{xfer}};   // only the granted buffer

endmodule

`default_nettype wire

// File: logic/routerOutput.sv
`default_nettype none

module routerOutput
  import nocPkg::*, arbPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] inValid,
  input  flitT                inFlit [numPorts],
  output logic [numPorts-1:0] inReady,
  output logic                outValid,
  output outFlitT             outFlit,
  input  logic                outReady
);

  logic [numPorts-1:0] notEmpty;
  flitT                headFlit [numPorts];
  logic [numPorts-1:0] pop;
  grantT               grant;
  logic                xfer;
  flitT                xferFlit;

  //**************************************************************************
  // input buffers
  //**************************************************************************

  for (genvar p = 0; p < numPorts; p++)
  begin : genBuf
    flitBuffer buffer (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[p]),
      .inFlit   (inFlit[p]),
      .inReady  (inReady[p]),
      .pop      (pop[p]),
      .notEmpty (notEmpty[p]),
      .headFlit (headFlit[p])
    );
  end

  //**************************************************************************
  // arbitration and output
  //**************************************************************************

  portArbiter arbiter (
    .clk      (clk),
    .rst      (rst),
    .req      (notEmpty),   // any buffered flit is a request
    .xfer     (xfer),
    .xferFlit (xferFlit),
    .grant    (grant)
  );

  outputMux mux (
    .grant    (grant),
    .notEmpty (notEmpty),
    .headFlit (headFlit),
    .outReady (outReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .xfer     (xfer),
    .xferFlit (xferFlit),
    .pop      (pop)
  );

endmodule

`default_nettype wire

// File: sim/tbRouterOutput.sv
`default_nettype none

module tbRouterOutput
  import nocPkg::*;
();

  localparam int caseMax = 256;
  localparam int slots   = 256;

  logic                clk = 1'b0;
  logic                rst;
  logic [numPorts-1:0] inValid;
  flitT                inFlit [numPorts];
  logic [numPorts-1:0] inReady;
  logic                outValid;
  outFlitT             outFlit;
  logic                outReady;

  logic [15:0]         caseMem [caseMax];
  flitT                sendMem [numPorts][slots];     // per-port scoreboard
  pktLenT              pktLenMem [numPorts][slots];
  int                  queuedCnt [numPorts] = '{default: 0};
  int                  acceptCnt [numPorts] = '{default: 0};
  int                  delivCnt [numPorts] = '{default: 0};
  int                  pktCnt [numPorts] = '{default: 0};
  int                  pktIdx [numPorts] = '{default: 0};
  int                  basePkt [numPorts] = '{default: 0};
  logic [numPorts-1:0] readyS = '0;
  portIdT              headOrder [$];
  logic [31:0]         lcgState = 32'hc193;
  int                  phase = 0;
  logic                holdDone = 1'b0;
  int                  errors = 0;
  int                  inTotal = 0;
  int                  outTotal = 0;
  int                  watchLimit = 0;
  logic                pktOpen = 1'b0;
  logic                fullSeen = 1'b0;
  portIdT              curSrc;
  pktLenT              curLen;
  pktLenT              seenLen;

  routerOutput DUT (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inReady  (inReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outReady (outReady)
  );

  always #5 clk = ~clk;

  //**************************************************************************
  // compare tasks
  //**************************************************************************

  task automatic checkFlit(input string name, input flitT got, input flitT exp);
    if (got !== exp)
    begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic checkPort(input string name, input portIdT got, input portIdT exp);
    if (got !== exp)
    begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic checkLength(input string name, input pktLenT got, input pktLenT exp);
    if (got !== exp)
    begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic checkFlags(input string name, input logic [numPorts-1:0] got,
                            input logic [numPorts-1:0] exp);
    if (got !== exp)
    begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // next waiting port in ring order after cur, L first from idle
  function automatic int pickPort(input int pending [numPorts], input int cur);
    int idx;
    if (cur >= 0)
    begin
      for (int k = 1; k < numPorts; k++)
      begin
        idx = (cur + k) % numPorts;
        if (pending[idx] > 0)
          return idx;
      end
    end
    for (int p = 0; p < numPorts; p++)
    begin
      if (pending[p] > 0)
        return p;
    end
    return -1;
  endfunction

  task automatic waitCycle();
    @(posedge clk);
    #2;   // away from both clock edges
  endtask

  task automatic addPacket(input int p, input pktLenT len, input flitDataT first);
    pktLenT effLen;
    flitT   f;
    effLen = (len == '0) ? pktLenT'(1) : len;
    for (int k = 0; k < int'(effLen); k++)
    begin
      f.kind = (k == 0) ? flitHead : (k == int'(effLen) - 1) ? flitTail : flitBody;
      f.data = (k == 0) ? {first[15:pktLenW], len} : first + flitDataT'(k - 1);
      sendMem[p][queuedCnt[p]] = f;
      queuedCnt[p]++;
      inTotal++;
    end
    pktLenMem[p][pktCnt[p]] = effLen;
    pktCnt[p]++;
  endtask

  task automatic trackFlit(input outFlitT f);
    int src;
    src = int'(f.srcPort);
    if (src >= numPorts || delivCnt[src] >= acceptCnt[src])
    begin
      $display("output flit from port %0d was never accepted at an input", src);
      errors++;
      return;
    end
    checkFlit("outFlit.flit", f.flit, sendMem[src][delivCnt[src]]);
    delivCnt[src]++;
    outTotal++;
    if (f.flit.kind == flitHead)
    begin
      if (pktOpen)
      begin
        $display("head from port %0d cut into an open packet at %0t", src, $time);
        errors++;
      end
      curSrc  = f.srcPort;
      curLen  = pktLenMem[src][pktIdx[src]];
      seenLen = pktLenT'(1);
      pktIdx[src]++;
      pktOpen = (curLen != pktLenT'(1));
      if (phase == 3)
        headOrder.push_back(f.srcPort);
    end
    else
    begin
      if (!pktOpen)
      begin
        $display("flit from port %0d arrived outside any packet at %0t", src, $time);
        errors++;
      end
      checkPort("outFlit.srcPort", f.srcPort, curSrc);   // no interleaving
      seenLen++;
      if (f.flit.kind == flitTail)
      begin
        checkLength("packet length", seenLen, curLen);
        pktOpen = 1'b0;
      end
    end
  endtask

  task automatic drainPhase();
    logic   loaded;
    int     pending [numPorts];
    int     cur;
    int     want;
    portIdT expOrder [$];
    if (phase == 3)
    begin
      loaded = 1'b0;
      while (!loaded)
      begin
        waitCycle();
        loaded = 1'b1;
        for (int p = 0; p < numPorts; p++)
        begin
          want = queuedCnt[p] - delivCnt[p];
          want = (want > bufDepth) ? bufDepth : want;
          if (acceptCnt[p] - delivCnt[p] < want)
            loaded = 1'b0;
        end
      end
      holdDone = 1'b1;
    end
    while (outTotal != inTotal)
      waitCycle();
    if (phase == 3)
    begin
      for (int p = 0; p < numPorts; p++)
        pending[p] = pktCnt[p] - basePkt[p];
      cur = pickPort(pending, -1);
      while (cur >= 0)
      begin
        expOrder.push_back(portIdT'(cur));
        pending[cur]--;
        cur = pickPort(pending, cur);
      end
      if (headOrder.size() != expOrder.size())
      begin
        $display("phase 3 sent %0d packets but %0d heads left the output",
                 expOrder.size(), headOrder.size());
        errors++;
      end
      else
      begin
        foreach (expOrder[k])
          checkPort("phase 3 head order", headOrder[k], expOrder[k]);
      end
    end
  endtask

  //**************************************************************************
  // drivers, output back-pressure and monitor
  //**************************************************************************

  // one driver per input port
  always @(posedge clk)
  begin
    for (int p = 0; p < numPorts; p++)
    begin
      if (rst)
        inValid[p] <= 1'b0;
      else
      begin
        if (inValid[p] && readyS[p])
          acceptCnt[p] = acceptCnt[p] + 1;
        inValid[p] <= (acceptCnt[p] < queuedCnt[p]);
        inFlit[p]  <= sendMem[p][acceptCnt[p]];
      end
    end
  end

  always @(posedge clk)
  begin
    if (rst)
      outReady <= 1'b0;
    else if (phase == 3)
      outReady <= holdDone;   // low until every port is loaded
    else
    begin
      lcgState = lcgNext(lcgState);
      outReady <= (lcgState[21:20] != 2'b00);
    end
  end

  always @(negedge clk)
  begin : monitor
    logic [numPorts-1:0] expReady;
    readyS = inReady;
    if (!rst)
    begin
      for (int p = 0; p < numPorts; p++)
        expReady[p] = ((acceptCnt[p] - delivCnt[p]) != bufDepth);
      checkFlags("inReady", inReady, expReady);
      if (inReady != '1)
        fullSeen = 1'b1;
      if (outValid && outReady)
        trackFlit(outFlit);   // transfer at the coming edge
    end
  end

  initial
  begin : watchdog
    wait (watchLimit != 0);
    repeat (watchLimit) @(posedge clk);
    $display("watchdog expired after %0d cycles with flits still pending", watchLimit);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin : main
    int     i;
    int     totalFlits;
    pktLenT len;
    rst      = 1'b1;
    inValid  = '0;
    outReady = 1'b0;
    for (int p = 0; p < numPorts; p++)
      inFlit[p] = '0;
    $readmemh("sim/routerCases.txt", caseMem);
    totalFlits = 0;
    i = 0;
    while (i < caseMax - 2 && caseMem[i] != 16'h000e)
    begin
      len = pktLenT'(caseMem[i + 1]);
      if (caseMem[i] < numPorts)
        totalFlits += (len == '0) ? 1 : int'(len);
      i += 3;
    end
    if (totalFlits == 0)
    begin
      $display("no packets found in the case file");
      errors++;
    end
    watchLimit = totalFlits * 40;

    repeat (8) @(posedge clk);
    rst <= 1'b0;
    #2;
    checkFlags("outValid", numPorts'(outValid), '0);
    checkFlags("inReady", inReady, '1);

    i = 0;
    while (i < caseMax - 2 && caseMem[i] != 16'h000e)
    begin
      if (caseMem[i] == 16'h000f)
      begin
        drainPhase();
        for (int p = 0; p < numPorts; p++)
          basePkt[p] = pktCnt[p];
        phase = int'(caseMem[i + 1]);
      end
      else if (caseMem[i] < numPorts)
        addPacket(int'(caseMem[i]), pktLenT'(caseMem[i + 1]), caseMem[i + 2]);
      else
      begin
        $display("case file row %0d names port %0d, which does not exist", i / 3, caseMem[i]);
        errors++;
      end
      i += 3;
    end
    drainPhase();

    if (!fullSeen)
    begin
      $display("no input buffer ever filled up");
      errors++;
    end
    $display("errors %0d, flits in %0d, flits out %0d", errors, inTotal, outTotal);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/routerCases.txt
// columns: source port, packet length in flits, first payload word (all hex)
// port F marks a phase start with the phase number in the length column, port E ends the list
F 001 0000
0 003 0a10
2 001 2b00
4 005 4c20
1 000 1d00
F 002 0000
0 006 0100
1 004 1200
2 007 2300
3 002 3400
4 008 4500
3 005 3600
0 001 0700
F 003 0000
0 004 0800
1 002 1900
2 003 2a00
3 004 3b00
4 001 4c00
1 003 1d10
3 002 3e10
E 000 0000

// File: tb.f
logic/nocPkg.sv
logic/arbPkg.sv
logic/flitBuffer.sv
logic/packetTimer.sv
logic/portArbiter.sv
logic/outputMux.sv
logic/routerOutput.sv
sim/tbRouterOutput.sv
